// File: ifu_pkg.sv
package ifu_pkg;

    // byte address and instruction word
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;

    // AXI read response
    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_SLVERR = 2'd2;

    // fetch sequencer states
    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        DELIVER
    } seq_state_t;

    // ROM image, one 32-bit word per line
    localparam string ROM_FILE = "inst_rom.hex";

endpackage

// File: ifu_axi_master.sv
`timescale 1ns/1ns

module ifu_axi_master import ifu_pkg::*; (
    input  logic  clk,
    input  logic  rst,

    // request side, one read at a time
    input  addr_t req_addr,
    input  logic  req_en,
    output word_t rdata,
    output resp_t rresp,
    output logic  finish,

    // read address channel
    output addr_t araddr,
    output logic  arvalid,
    input  logic  arready,

    // read data channel
    input  word_t axi_rdata,
    input  resp_t axi_rresp,
    input  logic  rvalid,
    output logic  rready
);

    logic ar_hs;
    logic r_hs;

    assign ar_hs = arvalid && arready;
    assign r_hs  = rvalid && rready;

    // address is only looked at while arvalid is high
    always_ff @(posedge clk) begin
        if (req_en) begin
            araddr <= req_addr;
        end
    end

    // arvalid held until the slave takes the address
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            arvalid <= 1'b0;
        end else if (ar_hs) begin
            arvalid <= 1'b0;
        end else if (req_en) begin
            arvalid <= 1'b1;
        end
    end

    // ready for data once the address is accepted
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rready <= 1'b0;
        end else if (r_hs) begin
            rready <= 1'b0;
        end else if (ar_hs) begin
            rready <= 1'b1;
        end
    end

    // word and response kept until the next read completes
    always_ff @(posedge clk) begin
        if (r_hs) begin
            rdata <= axi_rdata;
            rresp <= axi_rresp;
        end
    end

    // finish is the data handshake delayed by one cycle,
    // so rdata is already stable when it is seen
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            finish <= 1'b0;
        end else begin
            finish <= r_hs;
        end
    end

endmodule

// File: fetch_sequencer.sv
`timescale 1ns/1ns

module fetch_sequencer import ifu_pkg::*; #(
    parameter addr_t RESET_PC = '0
) (
    input  logic  clk,
    input  logic  rst,

    // core control
    input  logic  fetch_en,
    input  logic  redirect,
    input  addr_t redirect_pc,

    // to and from the read master
    output addr_t req_addr,
    output logic  req_en,
    input  word_t rdata,
    input  resp_t rresp,
    input  logic  finish,

    // instruction output
    output logic  inst_valid,
    output word_t inst,
    output addr_t inst_pc,
    output logic  inst_fault
);

    seq_state_t state;
    seq_state_t state_nxt;
    addr_t      pc;
    logic       discard;
    logic       issue;
    logic       done;

    // a redirect takes the cycle, the request goes out on the next one
    assign issue = (state == IDLE || state == DELIVER) && fetch_en && !redirect;
    assign done  = (state == WAIT) && finish;

    assign req_en   = issue;
    assign req_addr = pc;

    // master holds the word until the next read completes
    assign inst_valid = (state == DELIVER);
    assign inst       = rdata;
    assign inst_fault = (rresp != RESP_OKAY);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (issue) begin
                    state_nxt = WAIT;
                end
            end
            WAIT: begin
                // a redirect in the finish cycle also kills the result
                if (finish) begin
                    state_nxt = (discard || redirect) ? IDLE : DELIVER;
                end
            end
            DELIVER: begin
                state_nxt = issue ? WAIT : IDLE;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // redirect wins over the sequential step
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (done && !discard) begin
            pc <= pc + addr_t'(4);
        end
    end

    // read in flight belongs to the old stream
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            discard <= 1'b0;
        end else if (done) begin
            discard <= 1'b0;
        end else if (state == WAIT && redirect) begin
            discard <= 1'b1;
        end
    end

    // pc of the word about to be delivered
    always_ff @(posedge clk) begin
        if (done) begin
            inst_pc <= pc;
        end
    end

endmodule

// File: axi_inst_rom.sv
`timescale 1ns/1ns

module axi_inst_rom import ifu_pkg::*; #(
    parameter int ROM_AW = 6
) (
    input  logic  clk,
    input  logic  rst,

    // read address channel
    input  addr_t araddr,
    input  logic  arvalid,
    output logic  arready,

    // read data channel
    output word_t rdata,
    output resp_t rresp,
    output logic  rvalid,
    input  logic  rready
);

    localparam int    DEPTH     = 1 << ROM_AW;
    localparam addr_t ROM_BYTES = addr_t'(DEPTH) << 2;

    word_t             mem [DEPTH];
    logic [15:0]       lfsr;
    logic              lfsr_fb;
    logic [1:0]        ar_cnt;
    logic [1:0]        r_cnt;
    logic              pend;
    logic              ar_hs;
    logic              r_hs;
    logic              in_range;
    logic [ROM_AW-1:0] widx;

    // unloaded words read as zero
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
        $readmemh(ROM_FILE, mem);
    end

    assign widx     = araddr[ROM_AW+1:2];
    assign in_range = (araddr < ROM_BYTES);

    assign ar_hs = arvalid && arready;
    assign r_hs  = rvalid && rready;

    // one read at a time, no new address while data is pending
    assign arready = !pend && (ar_cnt == 2'd0);
    assign rvalid  = pend && (r_cnt == 2'd0);

    // x^16 + x^14 + x^13 + x^11 + 1
    assign lfsr_fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr <= 16'hace1;
        end else begin
            lfsr <= {lfsr[14:0], lfsr_fb};
        end
    end

    // address delay of 0 to 3 cycles, counted while arvalid waits
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ar_cnt <= 2'd0;
        end else if (r_hs) begin
            ar_cnt <= lfsr[5:4];
        end else if (arvalid && !pend && ar_cnt != 2'd0) begin
            ar_cnt <= ar_cnt - 2'd1;
        end
    end

    // rvalid comes r_cnt + 1 cycles after the address handshake
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pend  <= 1'b0;
            r_cnt <= 2'd0;
        end else if (ar_hs) begin
            pend  <= 1'b1;
            r_cnt <= lfsr[1:0];
        end else if (r_hs) begin
            pend <= 1'b0;
        end else if (pend && r_cnt != 2'd0) begin
            r_cnt <= r_cnt - 2'd1;
        end
    end

    // looked up at the address handshake, held until rready
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            if (in_range) begin
                rdata <= mem[widx];
                rresp <= RESP_OKAY;
            end else begin
                rdata <= '0;
                rresp <= RESP_SLVERR;
            end
        end
    end

endmodule

// File: ifu_top.sv
`timescale 1ns/1ns

module ifu_top import ifu_pkg::*; #(
    parameter addr_t RESET_PC = '0,
    parameter int    ROM_AW   = 6
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  fetch_en,
    input  logic  redirect,
    input  addr_t redirect_pc,
    output logic  inst_valid,
    output word_t inst,
    output addr_t inst_pc,
    output logic  inst_fault
);

    // sequencer to master
    addr_t req_addr;
    logic  req_en;
    word_t req_rdata;
    resp_t req_rresp;
    logic  finish;

    // AXI-lite read channels
    addr_t araddr;
    logic  arvalid;
    logic  arready;
    word_t rdata;
    resp_t rresp;
    logic  rvalid;
    logic  rready;

    fetch_sequencer #(
        .RESET_PC(RESET_PC)
    ) u_fetch_sequencer (
        .clk        (clk),
        .rst        (rst),
        .fetch_en   (fetch_en),
        .redirect   (redirect),
        .redirect_pc(redirect_pc),
        .req_addr   (req_addr),
        .req_en     (req_en),
        .rdata      (req_rdata),
        .rresp      (req_rresp),
        .finish     (finish),
        .inst_valid (inst_valid),
        .inst       (inst),
        .inst_pc    (inst_pc),
        .inst_fault (inst_fault)
    );

    ifu_axi_master u_ifu_axi_master (
        .clk      (clk),
        .rst      (rst),
        .req_addr (req_addr),
        .req_en   (req_en),
        .rdata    (req_rdata),
        .rresp    (req_rresp),
        .finish   (finish),
        .araddr   (araddr),
        .arvalid  (arvalid),
        .arready  (arready),
        .axi_rdata(rdata),
        .axi_rresp(rresp),
        .rvalid   (rvalid),
        .rready   (rready)
    );

    axi_inst_rom #(
        .ROM_AW(ROM_AW)
    ) u_axi_inst_rom (
        .clk    (clk),
        .rst    (rst),
        .araddr (araddr),
        .arvalid(arvalid),
        .arready(arready),
        .rdata  (rdata),
        .rresp  (rresp),
        .rvalid (rvalid),
        .rready (rready)
    );

endmodule

// File: ifu_assertions.sv
`timescale 1ns/1ns

module ifu_assertions (
    input logic clk,
    input logic rst,
    input logic arvalid,
    input logic arready,
    input logic rready,
    input logic inst_valid
);

    // address stays offered until the slave takes it
    property arvalid_held;
        @(posedge clk) disable iff (rst)
            arvalid && !arready |=> arvalid;
    endproperty

    // data phase never overlaps the address phase
    property no_rready_with_arvalid;
        @(posedge clk) disable iff (rst)
            !(rready && arvalid);
    endproperty

    property inst_valid_single;
        @(posedge clk) disable iff (rst)
            inst_valid |=> !inst_valid;
    endproperty

    a_arvalid_held: assert property (arvalid_held)
        else $error("arvalid dropped before arready");

    a_no_rready_with_arvalid: assert property (no_rready_with_arvalid)
        else $error("rready high while arvalid is high");

    a_inst_valid_single: assert property (inst_valid_single)
        else $error("inst_valid high for two cycles in a row");

endmodule

bind ifu_top ifu_assertions u_ifu_assertions (
    .clk       (clk),
    .rst       (rst),
    .arvalid   (arvalid),
    .arready   (arready),
    .rready    (rready),
    .inst_valid(inst_valid)
);

// File: tb_ifu_top.sv
`timescale 1ns/1ns

module tb_ifu_top import ifu_pkg::*; ();

    localparam addr_t RESET_PC  = 32'h0000_0010;
    localparam int    ROM_AW    = 6;
    localparam int    ROM_WORDS = 1 << ROM_AW;
    localparam int    NUM_ROWS  = 8;
    localparam int    TIMEOUT   = 50;

    logic  clk;
    logic  rst;
    logic  fetch_en;
    logic  redirect;
    addr_t redirect_pc;
    logic  inst_valid;
    word_t inst;
    addr_t inst_pc;
    logic  inst_fault;

    word_t  rom_model [ROM_WORDS];
    addr_t  exp_pc;
    integer seed;

    // stimulus table, a hold of -1 picks a random length
    string row_name   [NUM_ROWS];
    logic  row_redir  [NUM_ROWS];
    addr_t row_target [NUM_ROWS];
    int    row_count  [NUM_ROWS];
    int    row_hold   [NUM_ROWS];

    ifu_top #(
        .RESET_PC(RESET_PC),
        .ROM_AW  (ROM_AW)
    ) u_ifu_top (
        .clk        (clk),
        .rst        (rst),
        .fetch_en   (fetch_en),
        .redirect   (redirect),
        .redirect_pc(redirect_pc),
        .inst_valid (inst_valid),
        .inst       (inst),
        .inst_pc    (inst_pc),
        .inst_fault (inst_fault)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic set_row(input int r, input string name, input logic redir,
                           input addr_t target, input int count, input int hold);
        row_name[r]   = name;
        row_redir[r]  = redir;
        row_target[r] = target;
        row_count[r]  = count;
        row_hold[r]   = hold;
    endtask

    task automatic load_table();
        set_row(0, "sequential", 1'b0, 32'h0, 6, 0);
        set_row(1, "redirect_in_flight", 1'b1, 32'h40, 5, 0);
        set_row(2, "redirect_from_idle", 1'b1, 32'h80, 4, 16);
        set_row(3, "fetch_hold", 1'b0, 32'h0, 3, -1);
        // last loaded words, then the zero fill
        set_row(4, "rom_tail", 1'b1, 32'hb8, 4, 0);
        set_row(5, "out_of_range", 1'b1, 32'h400, 3, 0);
        set_row(6, "back_in_range", 1'b1, 32'h8, 5, -1);
        set_row(7, "fetch_hold_long", 1'b0, 32'h0, 3, 24);
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %h actual %h", what, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch in %s", what);
        end
    endtask

    // compare one delivered word with the ROM model at exp_pc
    task automatic check_delivery(input string name);
        logic  in_range;
        word_t exp_word;
        in_range = exp_pc < addr_t'(ROM_WORDS * 4);
        exp_word = in_range ? rom_model[exp_pc[ROM_AW+1:2]] : '0;
        check_value({name, " inst_pc"}, exp_pc, inst_pc);
        check_value({name, " inst"}, exp_word, inst);
        check_value({name, " inst_fault"}, {31'b0, !in_range}, {31'b0, inst_fault});
        exp_pc = exp_pc + 32'd4;
    endtask

    task automatic observe_cycle(input string name, output bit seen);
        @(negedge clk);
        seen = inst_valid;
        if (seen) begin
            check_delivery(name);
        end
    endtask

    // the read already in flight comes out, nothing after it
    task automatic hold_fetch(input string name, input int cycles);
        int delivered;
        bit seen;
        delivered = 0;
        @(posedge clk);
        fetch_en <= 1'b0;
        for (int i = 0; i < cycles; i++) begin
            observe_cycle(name, seen);
            if (seen) begin
                delivered++;
            end
        end
        if (delivered != 1) begin
            $display("%s delivered %0d instructions while fetch_en was low instead of 1",
                     name, delivered);
            $display("TESTS FAILED");
            $fatal(1, "wrong delivery count while fetch was disabled");
        end
    endtask

    task automatic pulse_redirect(input string name, input addr_t target);
        bit seen;
        @(posedge clk);
        redirect    <= 1'b1;
        redirect_pc <= target;
        // a word shown in the redirect cycle still belongs to the old stream
        observe_cycle(name, seen);
        exp_pc = target;
        @(posedge clk);
        redirect <= 1'b0;
        observe_cycle(name, seen);
    endtask

    task automatic collect(input string name, input int count);
        bit seen;
        int waited;
        if (!fetch_en) begin
            @(posedge clk);
            fetch_en <= 1'b1;
        end
        for (int n = 0; n < count; n++) begin
            waited = 0;
            seen   = 1'b0;
            while (!seen && waited < TIMEOUT) begin
                observe_cycle(name, seen);
                waited++;
            end
            if (!seen) begin
                $display("no instruction within %0d cycles in %s", TIMEOUT, name);
                $display("TESTS FAILED");
                $fatal(1, "inst_valid timeout");
            end
        end
    endtask

    initial begin
        int hold;
        seed = 32'h2294_d372;
        rst         <= 1'b1;
        fetch_en    <= 1'b0;
        redirect    <= 1'b0;
        redirect_pc <= '0;
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom_model[i] = '0;
        end
        $readmemh(ROM_FILE, rom_model);
        load_table();
        exp_pc = RESET_PC;

        repeat (4) @(posedge clk);
        @(negedge clk);
        check_value("reset inst_valid", 32'd0, {31'b0, inst_valid});
        @(posedge clk);
        rst <= 1'b0;

        for (int r = 0; r < NUM_ROWS; r++) begin
            hold = row_hold[r];
            if (hold < 0) begin
                hold = 12 + ({$random(seed)} % 16);
            end
            if (hold > 0) begin
                hold_fetch(row_name[r], hold);
            end
            if (row_redir[r]) begin
                pulse_redirect(row_name[r], row_target[r]);
            end
            collect(row_name[r], row_count[r]);
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: inst_rom.hex
// one 32-bit instruction word per line, word address 0 first
00000093
00100113
00a00193
002081b3
40208233
0020f2b3
0020e333
0020c3b3
00209433
0020d4b3
4020d533
0020a5b3
0020b633
00112023
00012683
00410713
fff00793
00179813
0017d893
4017d913
123459b7
00001a17
00208463
00209463
0020c463
0020d463
0020e463
0020f463
008000ef
00008067
00410a93
01500b13
016a8bb3
00b12223
00412c03
00211423
00811c83
00210623
00c14d03
7ff00d93
800d8e13
01ce0eb3
0000000f
0000100f
00000073
00100073
00000013
fe000ee3

// File: ifu_top.f
ifu_pkg.sv
ifu_axi_master.sv
fetch_sequencer.sv
axi_inst_rom.sv
ifu_top.sv
ifu_assertions.sv
tb_ifu_top.sv

// File: run.sh
#!/bin/sh
# build and run the fetch unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f ifu_top.f --top-module tb_ifu_top
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/Vtb_ifu_top
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0
